//--- design/line_store.sv
`timescale 1ns/1ps
`include "rocache_macros.svh"

module line_store import rocache_types_pkg::*, rocache_ctrl_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  lookup_if.execute_mp lookup,
  result_if.source_mp  result,
  input  logic         flush_req_i,
  output logic         flush_ack_o,
  output logic         mem_req_o,
  output addr_t        mem_addr_o,
  input  logic         mem_ack_i,
  input  data_t        mem_rdata_i
);

  store_state_e             state_q;
  addr_t                    req_addr_q;
  route_e                   route_q;
  tag_t                     req_tag;
  index_t                   req_idx;
  offset_t                  req_off;
  tag_t                     tag_q [`RC_LINE_COUNT];
  data_t                    data_q [`RC_LINE_COUNT][`RC_LINE_WORDS];
  logic [`RC_LINE_COUNT-1:0] valid_q;
  offset_t                  word_q;
  index_t                   flush_idx_q;
  logic                     mem_req_q;
  logic                     flush_ack_q;
  data_t                    rdata_q;
  logic                     hit_q;
  logic                     lookup_hit;
  logic                     flush_start;
  logic                     word_capture;
  logic                     word_release;
  logic                     last_word;
  logic                     fill_we;
  logic                     tag_we;

  // Address fields of the request in flight
  assign req_off = req_addr_q[`RC_OFFSET_W-1:0];
  assign req_idx = req_addr_q[`RC_OFFSET_W +: `RC_INDEX_W];
  assign req_tag = req_addr_q[`RC_ADDR_W-1 -: `RC_TAG_W];

  assign lookup_hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

  // Flush takes priority over a waiting lookup
  assign flush_start  = flush_req_i && !flush_ack_q;
  assign lookup.ready = (state_q == ST_IDLE) && !flush_start;

  // Memory four-phase phases
  assign word_capture = (state_q == ST_FETCH_WAIT) && mem_req_q && mem_ack_i;
  assign word_release = (state_q == ST_FETCH_WAIT) && !mem_req_q && !mem_ack_i;
  assign last_word    = (word_q == offset_t'(`RC_LINE_WORDS - 1));

  assign fill_we = word_capture && (route_q == ROUTE_CACHE);
  assign tag_we  = word_release && (route_q == ROUTE_CACHE) && last_word;

  // ----------------------------------------
  // Controller
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= ST_IDLE;
      valid_q     <= '0;
      word_q      <= '0;
      flush_idx_q <= '0;
      mem_req_q   <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (flush_ack_q && !flush_req_i) begin
            flush_ack_q <= 1'b0;
          end
          if (flush_start) begin
            flush_idx_q <= '0;
            state_q     <= ST_FLUSH;
          end else if (lookup.valid) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          word_q <= '0;
          if ((route_q == ROUTE_CACHE) && lookup_hit) begin
            state_q <= ST_DELIVER;
          end else begin
            state_q <= ST_FETCH_REQ;
          end
        end
        ST_FETCH_REQ: begin
          mem_req_q <= 1'b1;
          state_q   <= ST_FETCH_WAIT;
        end
        ST_FETCH_WAIT: begin
          if (word_capture) begin
            mem_req_q <= 1'b0;
          end
          if (word_release) begin
            if ((route_q == ROUTE_BYPASS) || last_word) begin
              if (route_q == ROUTE_CACHE) begin
                valid_q[req_idx] <= 1'b1;
              end
              state_q <= ST_DELIVER;
            end else begin
              word_q  <= word_q + 1'b1;
              state_q <= ST_FETCH_REQ;
            end
          end
        end
        ST_DELIVER: begin
          if (result.done) begin
            state_q <= ST_IDLE;
          end
        end
        ST_FLUSH: begin
          // One line per cycle
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == index_t'(`RC_LINE_COUNT - 1)) begin
            flush_ack_q <= 1'b1;
            state_q     <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Payload and arrays
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (lookup.valid && lookup.ready) begin
      req_addr_q <= lookup.addr;
      route_q    <= lookup.route;
    end
    if (state_q == ST_LOOKUP) begin
      rdata_q <= data_q[req_idx][req_off];
      hit_q   <= (route_q == ROUTE_CACHE) && lookup_hit;
    end
    // Keep the requested word as the line streams in
    if (word_capture && ((route_q == ROUTE_BYPASS) || (word_q == req_off))) begin
      rdata_q <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_we) begin
      data_q[req_idx][word_q] <= mem_rdata_i;
    end
    if (tag_we) begin
      tag_q[req_idx] <= req_tag;
    end
  end

  // Refill walks the line, bypass uses the client address
  assign mem_addr_o = (route_q == ROUTE_CACHE) ? {req_tag, req_idx, word_q} : req_addr_q;
  assign mem_req_o  = mem_req_q;

  assign flush_ack_o  = flush_ack_q;
  assign result.valid = (state_q == ST_DELIVER);
  assign result.data  = rdata_q;
  assign result.hit   = hit_q;

endmodule

//--- design/lookup_if.sv
`timescale 1ns/1ps

// Routed read requests, decode to execute
interface lookup_if import rocache_types_pkg::*; ();

  logic   valid;
  logic   ready;
  addr_t  addr;
  route_e route;

  // Transfer on valid and ready both high
  modport decode_mp (
    output valid,
    output addr,
    output route,
    input  ready
  );

  modport execute_mp (
    input  valid,
    input  addr,
    input  route,
    output ready
  );

endinterface

//--- design/region_decode.sv
`timescale 1ns/1ps

module region_decode import rocache_types_pkg::*, rocache_ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_i,
  input  addr_t       addr_i,
  input  logic        enable_i,
  input  addr_t       start_addr_i,
  input  addr_t       end_addr_i,
  lookup_if.decode_mp lookup
);

  decode_state_e state_q;
  logic          valid_q;
  addr_t         addr_q;
  route_e        route_q;
  logic          in_window;
  logic          accept;

  // Window is start inclusive, end exclusive
  assign in_window = (addr_i >= start_addr_i) && (addr_i < end_addr_i);
  assign accept    = (state_q == DC_IDLE) && req_i;

  // ----------------------------------------
  // One issue per held request
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= DC_IDLE;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        DC_IDLE: begin
          if (req_i) begin
            valid_q <= 1'b1;
            state_q <= DC_ISSUED;
          end
        end
        DC_ISSUED: begin
          if (valid_q && lookup.ready) begin
            valid_q <= 1'b0;
            state_q <= DC_RELEASE;
          end
        end
        DC_RELEASE: begin
          // Client still holds req until its ack arrives
          if (!req_i) begin
            state_q <= DC_IDLE;
          end
        end
        default: state_q <= DC_IDLE;
      endcase
    end
  end

  // Sample address and route on a new request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      route_q <= (enable_i && in_window) ? ROUTE_CACHE : ROUTE_BYPASS;
    end
  end

  assign lookup.valid = valid_q;
  assign lookup.addr  = addr_q;
  assign lookup.route = route_q;

endmodule

//--- design/response_return.sv
`timescale 1ns/1ps

module response_return import rocache_types_pkg::*, rocache_ctrl_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      req_i,
  result_if.sink_mp result,
  output logic      ack_o,
  output data_t     rdata_o,
  output logic      hit_o
);

  return_state_e state_q;
  data_t         rdata_q;
  logic          hit_q;

  // ----------------------------------------
  // Client acknowledge phase
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= RT_IDLE;
    end else begin
      case (state_q)
        RT_IDLE: begin
          if (result.valid) begin
            state_q <= RT_ACK;
          end
        end
        RT_ACK: begin
          // Hold ack until the client lets go
          if (!req_i) begin
            state_q <= RT_DONE;
          end
        end
        RT_DONE: state_q <= RT_IDLE;
        default: state_q <= RT_IDLE;
      endcase
    end
  end

  // Word and hit flag stay stable while ack is high
  always_ff @(posedge clk_i) begin
    if ((state_q == RT_IDLE) && result.valid) begin
      rdata_q <= result.data;
      hit_q   <= result.hit;
    end
  end

  assign ack_o       = (state_q == RT_ACK);
  assign result.done = (state_q == RT_DONE);
  assign rdata_o     = rdata_q;
  assign hit_o       = hit_q;

endmodule

//--- design/result_if.sv
`timescale 1ns/1ps

// Finished read words, execute to result
interface result_if import rocache_types_pkg::*; ();

  logic  valid;
  data_t data;
  logic  hit;
  logic  done;

  // Valid held until done pulse
  modport source_mp (
    output valid,
    output data,
    output hit,
    input  done
  );

  modport sink_mp (
    input  valid,
    input  data,
    input  hit,
    output done
  );

endinterface

//--- design/ro_cache_top.sv
`timescale 1ns/1ps

module ro_cache_top import rocache_types_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  // Cacheable window
  input  logic  enable_i,
  input  addr_t start_addr_i,
  input  addr_t end_addr_i,
  // Client
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  ack_o,
  output data_t rdata_o,
  output logic  hit_o,
  // Flush
  input  logic  flush_req_i,
  output logic  flush_ack_o,
  // Backing memory
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  input  logic  mem_ack_i,
  input  data_t mem_rdata_i
);

  lookup_if u_lookup_if ();
  result_if u_result_if ();

  // ----------------------------------------
  // Decode, execute, result
  // ----------------------------------------
  region_decode u_region_decode (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .enable_i     (enable_i),
    .start_addr_i (start_addr_i),
    .end_addr_i   (end_addr_i),
    .lookup       (u_lookup_if.decode_mp)
  );

  line_store u_line_store (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .lookup      (u_lookup_if.execute_mp),
    .result      (u_result_if.source_mp),
    .flush_req_i (flush_req_i),
    .flush_ack_o (flush_ack_o),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  response_return u_response_return (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .result  (u_result_if.sink_mp),
    .ack_o   (ack_o),
    .rdata_o (rdata_o),
    .hit_o   (hit_o)
  );

endmodule

//--- design/rocache_ctrl_pkg.sv
package rocache_ctrl_pkg;

  // Line store controller
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_FETCH_REQ,
    ST_FETCH_WAIT,
    ST_DELIVER,
    ST_FLUSH
  } store_state_e;

  // Client request decoder
  typedef enum logic [1:0] {
    DC_IDLE,
    DC_ISSUED,
    DC_RELEASE
  } decode_state_e;

  // Client acknowledge
  typedef enum logic [1:0] {
    RT_IDLE,
    RT_ACK,
    RT_DONE
  } return_state_e;

endpackage

//--- design/rocache_types_pkg.sv
`include "rocache_macros.svh"

package rocache_types_pkg;

  // ----------------------------------------
  // Data path vectors
  // ----------------------------------------

  // Word address as seen by client and memory
  typedef logic [`RC_ADDR_W-1:0]   addr_t;

  // One data word
  typedef logic [`RC_DATA_W-1:0]   data_t;

  // Address fields
  typedef logic [`RC_TAG_W-1:0]    tag_t;
  typedef logic [`RC_INDEX_W-1:0]  index_t;
  typedef logic [`RC_OFFSET_W-1:0] offset_t;

  // Where a read is served from
  typedef enum logic {
    ROUTE_BYPASS = 1'b0,
    ROUTE_CACHE  = 1'b1
  } route_e;

endpackage

//--- include/rocache_macros.svh
`ifndef ROCACHE_MACROS_SVH
`define ROCACHE_MACROS_SVH

// ----------------------------------------
// Cache geometry
// ----------------------------------------

// Word address and data widths
`define RC_ADDR_W      16
`define RC_DATA_W      32

// Line count and words per line of the direct mapped store
`define RC_LINE_COUNT  16
`define RC_LINE_WORDS  4

// Address split into tag, index and word offset
`define RC_INDEX_W     $clog2(`RC_LINE_COUNT)
`define RC_OFFSET_W    $clog2(`RC_LINE_WORDS)
`define RC_TAG_W       (`RC_ADDR_W - `RC_INDEX_W - `RC_OFFSET_W)

`endif

//--- run.sh
#!/usr/bin/env bash
# Build the simulation with Verilator and run it, pass only on the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ro_cache \
  -f sources.f -o tb_ro_cache_sim \
  && ./obj_dir/tb_ro_cache_sim | tee /dev/stderr | grep -q "TEST PASSED" \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

//--- sources.f
+incdir+include
design/rocache_types_pkg.sv
design/rocache_ctrl_pkg.sv
design/lookup_if.sv
design/result_if.sv
design/region_decode.sv
design/line_store.sv
design/response_return.sv
design/ro_cache_top.sv
tb/mem_responder.sv
tb/tb_ro_cache.sv

//--- tb/mem_responder.sv
`timescale 1ns/1ps

// Backing memory model that answers one four-phase read at a time
module mem_responder import rocache_types_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic [2:0] delay_i,
  input  data_t      word_i,
  input  logic       mem_req_i,
  output logic       mem_ack_o,
  output data_t      mem_rdata_o
);

  logic       ack_q;
  logic [2:0] wait_q;
  data_t      rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q  <= 1'b0;
      wait_q <= '0;
    end else if (ack_q) begin
      // Release once the requester lets go
      if (!mem_req_i) begin
        ack_q <= 1'b0;
      end
    end else if (mem_req_i) begin
      if (wait_q >= delay_i) begin
        ack_q   <= 1'b1;
        rdata_q <= word_i;
        wait_q  <= '0;
      end else begin
        wait_q <= wait_q + 3'd1;
      end
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;

endmodule

//--- tb/tb_ro_cache.sv
`timescale 1ns/1ps
`include "rocache_macros.svh"

module tb_ro_cache import rocache_types_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 500;
  localparam int RANDOM_READS   = 300;

  logic        clk;
  logic        reset;
  logic        win_enable;
  addr_t       win_start;
  addr_t       win_end;
  logic        client_req;
  addr_t       req_addr;
  logic        client_ack;
  data_t       rdata;
  logic        hit;
  logic        flush_req;
  logic        flush_ack;
  logic        mem_req;
  addr_t       mem_addr;
  logic        mem_ack;
  data_t       mem_rdata;
  data_t       mem_word_rd;
  logic [2:0]  mem_delay;
  logic [31:0] lfsr_q;
  string       cur_test;
  data_t       exp_data;
  logic        exp_hit;
  int          exp_reqs;
  int          reads_issued;
  int          checks_done;
  logic        ref_valid [`RC_LINE_COUNT];
  tag_t        ref_tag [`RC_LINE_COUNT];

  ro_cache_top DUT (
    .clk_i        (clk),
    .reset_i      (reset),
    .enable_i     (win_enable),
    .start_addr_i (win_start),
    .end_addr_i   (win_end),
    .req_i        (client_req),
    .addr_i       (req_addr),
    .ack_o        (client_ack),
    .rdata_o      (rdata),
    .hit_o        (hit),
    .flush_req_i  (flush_req),
    .flush_ack_o  (flush_ack),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_ack_i    (mem_ack),
    .mem_rdata_i  (mem_rdata)
  );

  mem_responder u_mem (
    .clk_i       (clk),
    .reset_i     (reset),
    .delay_i     (mem_delay),
    .word_i      (mem_word_rd),
    .mem_req_i   (mem_req),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers and reference model
  // ----------------------------------------
  task automatic report_error(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      value  = {value[30:0], lfsr_q[0]};
    end
    return value;
  endfunction

  // Memory contents depend on every address bit
  function automatic data_t mem_word(input addr_t addr);
    return {~addr, addr ^ 16'h3c5a} + 32'h9e37_0000;
  endfunction

  assign mem_word_rd = mem_word(mem_addr);

  // Direct mapped model that updates its state like a real access
  function automatic void predict(input addr_t addr, output data_t data,
                                  output logic is_hit, output int reqs);
    index_t idx;
    tag_t   tag;
    logic   cacheable;
    idx       = addr[`RC_OFFSET_W +: `RC_INDEX_W];
    tag       = addr[`RC_ADDR_W-1 -: `RC_TAG_W];
    cacheable = win_enable && (addr >= win_start) && (addr < win_end);
    data      = mem_word(addr);
    is_hit    = 1'b0;
    reqs      = 1;
    if (cacheable) begin
      if (ref_valid[idx] && (ref_tag[idx] == tag)) begin
        is_hit = 1'b1;
        reqs   = 0;
      end else begin
        reqs           = `RC_LINE_WORDS;
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
      end
    end
  endfunction

  task automatic wait_client_ack(input logic level);
    int cycles;
    cycles = 0;
    while (client_ack !== level) begin
      if (cycles == TIMEOUT_CYCLES) begin
        report_error($sformatf("Timeout in test %s, ack_o never went to %0b",
                               cur_test, level));
      end
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  task automatic wait_flush_ack(input logic level);
    int cycles;
    cycles = 0;
    while (flush_ack !== level) begin
      if (cycles == TIMEOUT_CYCLES) begin
        report_error($sformatf("Timeout in test %s, flush_ack_o never went to %0b",
                               cur_test, level));
      end
      @(posedge clk);
      #2;
      cycles++;
    end
  endtask

  // Called at the drive point 2 ns after an edge
  task automatic read_word(input addr_t addr);
    predict(addr, exp_data, exp_hit, exp_reqs);
    req_addr   = addr;
    client_req = 1'b1;
    wait_client_ack(1'b1);
    client_req = 1'b0;
    wait_client_ack(1'b0);
    reads_issued++;
  endtask

  task automatic flush_cache();
    flush_req = 1'b1;
    wait_flush_ack(1'b1);
    flush_req = 1'b0;
    wait_flush_ack(1'b0);
    for (int i = 0; i < `RC_LINE_COUNT; i++) begin
      ref_valid[i] = 1'b0;
    end
  endtask

  // ----------------------------------------
  // Compare process
  // ----------------------------------------
  initial begin : compare_reads
    logic mem_req_d;
    logic ack_d;
    int   req_count;
    mem_req_d = 1'b0;
    ack_d     = 1'b0;
    req_count = 0;
    forever begin
      @(posedge clk);
      if (mem_req === 1'b1 && mem_req_d !== 1'b1) begin
        req_count++;
      end
      if (client_ack === 1'b1 && ack_d !== 1'b1) begin
        assert (rdata === exp_data) else report_error($sformatf(
          "[ERROR] %s: rdata_o expected %h, actual %h", cur_test, exp_data, rdata));
        assert (hit === exp_hit) else report_error($sformatf(
          "[ERROR] %s: hit_o expected %0b, actual %0b", cur_test, exp_hit, hit));
        assert (req_count == exp_reqs) else report_error($sformatf(
          "[ERROR] %s: memory requests expected %0d, actual %0d",
          cur_test, exp_reqs, req_count));
        req_count = 0;
        checks_done++;
      end
      mem_req_d = mem_req;
      ack_d     = client_ack;
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    addr_t rand_addr;
    reset        = 1'b1;
    win_enable   = 1'b0;
    win_start    = '0;
    win_end      = '0;
    client_req   = 1'b0;
    req_addr     = '0;
    flush_req    = 1'b0;
    mem_delay    = 3'd2;
    lfsr_q       = 32'h3fb7_f2de;
    cur_test     = "reset";
    exp_data     = '0;
    exp_hit      = 1'b0;
    exp_reqs     = 0;
    reads_issued = 0;
    checks_done  = 0;
    for (int i = 0; i < `RC_LINE_COUNT; i++) begin
      ref_valid[i] = 1'b0;
      ref_tag[i]   = '0;
    end
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;

    // Line refill then hits on the same line
    cur_test   = "line_fill";
    win_enable = 1'b1;
    win_start  = 16'h0000;
    win_end    = 16'h0100;
    for (int w = 0; w < `RC_LINE_WORDS; w++) begin
      read_word(addr_t'(16'h0040 + w));
    end

    // Outside the window and with the cache disabled
    cur_test = "bypass";
    read_word(16'h0200);
    read_word(16'h0200);
    read_word(16'h0100);
    win_enable = 1'b0;
    read_word(16'h0041);
    win_enable = 1'b1;

    // Same index with different tags
    cur_test = "evict";
    read_word(16'h0010);
    read_word(16'h0050);
    read_word(16'h0010);
    read_word(16'h0050);

    cur_test = "flush";
    read_word(16'h0042);
    flush_cache();
    read_word(16'h0042);
    read_word(16'h0043);

    cur_test = "random";
    for (int n = 0; n < RANDOM_READS; n++) begin
      if (rand_bits(4) == 0) begin
        win_start = addr_t'(rand_bits(8));
        win_end   = win_start + addr_t'(rand_bits(8));
      end
      if (rand_bits(3) == 0) begin
        win_enable = ~win_enable;
      end
      if (rand_bits(5) == 0) begin
        flush_cache();
      end
      // Mostly a small address range so lines get reused
      if (rand_bits(3) == 0) begin
        rand_addr = addr_t'(rand_bits(16));
      end else begin
        rand_addr = addr_t'(rand_bits(8));
      end
      mem_delay = 3'(rand_bits(3));
      read_word(rand_addr);
    end

    if (checks_done == reads_issued) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_error($sformatf("Only %0d of %0d reads were acknowledged and checked",
                             checks_done, reads_issued));
    end
  end

endmodule
